// File: bitinfo.hex
// One 32-bit word per line; @ lines give the word index in hex
// Type record: word0 = {type[15:0], instance count}, word1 = {8'h00, type[39:16]}
@16
12340002
00000000
@21
00420004
00ABCDEF
@2C
00070001
00010000
// End marker, then a blank word1 that the parser reads but ignores
@37
FFFFFFFF
00000000

// File: compile.f
common/sched_pkg.sv
hdl/bitinfo_rom.sv
scheduler/sched_bitinfo_parser.sv
scheduler/sched_table_ram.sv
scheduler/sched_dispatch.sv
hdl/sched_axil_regs.sv
hdl/sched_top.sv
sim/tb_clock.sv
sim/sched_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the scheduler testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module sched_tb -f compile.f -o sched_sim

./obj_dir/sched_sim > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"

// File: sim/sched_tb.sv
/* Directed tests of sched_top over AXI4-Lite. Assumes bitinfo.hex holds three types
   with 2, 4 and 1 instances, and that the simulation runs from the project root */
`default_nettype none

module sched_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_types = 3;
  localparam int max_transfers = 200;           // Roughly 170 bus transfers in all tests
  localparam int cycles_per_transfer = 100;     // A transfer plus lookup takes far fewer
  localparam int timeout_cycles = max_transfers * cycles_per_transfer;
  localparam int poll_limit = 50;
  localparam int hold_cycles = 6;

  localparam logic [39:0] type_list [num_types] = '{
    40'h00_0000_1234, 40'hAB_CDEF_0042, 40'h01_0000_0007
  };
  localparam int inst_list [num_types] = '{2, 4, 1};

  logic                 clk;
  logic                 rstn;
  sched_pkg::axil_req_t axil_req;
  sched_pkg::axil_rsp_t axil_rsp;

  int errors;
  int checks;
  int cycle_count;
  int seed;
  int rr_pos [num_types];   // Expected round-robin position of each type

  tb_clock #(.period_ns(8)) tb_clock_inst (.clk);

  sched_top #(.MAX_ACCS(16), .MAX_ACC_TYPES(16)) sched_top_inst (
    .clk, .rstn, .axil_req, .axil_rsp
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // First id of a type is the sum of the instance counts before it
  function automatic int first_id(input int idx);
    int sum;
    sum = 0;
    for (int i = 0; i < idx; i++) begin
      sum += inst_list[i];
    end
    return sum;
  endfunction

  function automatic logic [7:0] take_rr_id(input int idx);
    int id;
    id = first_id(idx) + rr_pos[idx];
    rr_pos[idx] = (rr_pos[idx] + 1) % inst_list[idx];   // Wraps after the last instance
    return 8'(id);
  endfunction

  // Idle result word with busy low and table ready high
  function automatic logic [31:0] result_word(input logic hit, input logic [7:0] id);
    return {1'b0, hit, 1'b1, 21'd0, id};
  endfunction

  function automatic logic is_table_type(input logic [39:0] t);
    for (int i = 0; i < num_types; i++) begin
      if (type_list[i] == t) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite master tasks that start and end on a falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic axil_write(input logic [3:0] offset, input logic [31:0] data,
                            input int hold);
    axil_req.awaddr  = 32'(offset);
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = hold == 0;
    do @(negedge clk); while (!(axil_rsp.awready && axil_rsp.wready));
    @(negedge clk);   // Address and data went over on the last rising edge
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) @(negedge clk);
    check_value("bresp", 32'(axil_rsp.bresp), 32'd0);
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value("bvalid under back-pressure", 32'(axil_rsp.bvalid), 32'd1);
      check_value("bresp under back-pressure", 32'(axil_rsp.bresp), 32'd0);
    end
    axil_req.bready = 1'b1;
    @(negedge clk);
    check_value("bvalid after handshake", 32'(axil_rsp.bvalid), 32'd0);
  endtask

  task automatic axil_read(input logic [3:0] offset, input int hold,
                           output logic [31:0] data);
    axil_req.araddr  = 32'(offset);
    axil_req.arvalid = 1'b1;
    axil_req.rready  = hold == 0;
    do @(negedge clk); while (!axil_rsp.arready);
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    axil_req.araddr  = '0;   // The address only counts while arvalid is high
    while (!axil_rsp.rvalid) @(negedge clk);
    data = axil_rsp.rdata;
    check_value("rresp", 32'(axil_rsp.rresp), 32'd0);
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value("rvalid under back-pressure", 32'(axil_rsp.rvalid), 32'd1);
      check_value("rdata under back-pressure", axil_rsp.rdata, data);
    end
    axil_req.rready = 1'b1;
    @(negedge clk);
    check_value("rvalid after handshake", 32'(axil_rsp.rvalid), 32'd0);
  endtask

  // Writing type_hi launches the lookup
  task automatic start_lookup(input logic [39:0] t, input int lo_hold);
    axil_write(sched_pkg::reg_type_lo, t[31:0], lo_hold);
    axil_write(sched_pkg::reg_type_hi, 32'(t[39:32]), 0);
  endtask

  task automatic wait_result(output logic [31:0] word);
    int polls;
    polls = 0;
    do begin
      axil_read(sched_pkg::reg_result, 0, word);
      polls++;
    end while (word[sched_pkg::res_busy_bit] && polls < poll_limit);
    checks++;
    assert (!word[sched_pkg::res_busy_bit]) else begin
      errors++;
      $display("Lookup still busy after %0d polls of the result register", poll_limit);
    end
  endtask

  task automatic check_known(input int idx);
    logic [31:0] word;
    logic [7:0]  id;
    id = take_rr_id(idx);
    start_lookup(type_list[idx], 0);
    wait_result(word);
    check_value($sformatf("result for type %010h", type_list[idx]), word, result_word(1'b1, id));
  endtask

  task automatic check_miss(input logic [39:0] t);
    logic [31:0] word;
    start_lookup(t, 0);
    wait_result(word);
    check_value($sformatf("result for unknown type %010h", t), word, result_word(1'b0, 8'd0));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_table_ready();
    logic [31:0] word;
    int polls;
    polls = 0;
    do begin
      axil_read(sched_pkg::reg_result, 0, word);
      polls++;
    end while (!word[sched_pkg::res_ready_bit] && polls < poll_limit);
    checks++;
    assert (word[sched_pkg::res_ready_bit]) else begin
      errors++;
      $display("Table never reported ready after %0d polls", poll_limit);
    end
    check_value("result after parsing", word, result_word(1'b0, 8'd0));
    axil_read(sched_pkg::reg_num_types, 0, word);
    check_value("number of types", word, 32'(num_types));
  endtask

  task automatic test_each_type();
    for (int i = 0; i < num_types; i++) begin
      check_known(i);   // Ids 0, 2 and 6 on a fresh table
    end
  endtask

  task automatic test_round_robin();
    // Eight lookups cover the 4-instance type twice round
    for (int n = 0; n < 8; n++) begin
      check_known(1);
      if (n == 3) begin
        check_known(0);   // Other types keep their own position
        check_known(2);
      end
    end
    check_known(0);
  endtask

  task automatic test_unknown_types();
    logic [31:0] r_lo;
    logic [31:0] r_hi;
    logic [39:0] t;
    int tried;
    tried = 0;
    while (tried < 10) begin
      r_lo = $random(seed);
      r_hi = $random(seed);
      t = {r_hi[7:0], r_lo};
      if (!is_table_type(t)) begin
        check_known(2);   // Leaves id 6 in the result, which the miss has to clear
        check_miss(t);
        tried++;
      end
    end
  endtask

  task automatic test_back_pressure();
    logic [31:0] word;
    logic [7:0]  id;
    id = take_rr_id(2);
    start_lookup(type_list[2], hold_cycles);
    wait_result(word);
    check_value("result after held write response", word, result_word(1'b1, id));
    axil_read(sched_pkg::reg_result, hold_cycles, word);
    check_value("result with held read response", word, result_word(1'b1, id));

    // This result is never read before the next lookup replaces it
    start_lookup(type_list[0], 0);
    void'(take_rr_id(0));
    repeat (2 * num_types + 4) @(negedge clk);   // Longer than a full table scan
    id = take_rr_id(1);
    start_lookup(type_list[1], 0);
    wait_result(word);
    check_value("result after unread lookup", word, result_word(1'b1, id));
    check_known(0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Run control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    errors   = 0;
    checks   = 0;
    seed     = 91;
    rstn     = 1'b0;
    axil_req = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    for (int i = 0; i < num_types; i++) begin
      rr_pos[i] = 0;
    end
    repeat (8) @(negedge clk);
    rstn = 1'b1;

    test_table_ready();
    test_each_type();
    test_round_robin();
    test_unknown_types();
    test_back_pressure();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
/* Free-running testbench clock, starts low */
`default_nettype none

module tb_clock #(
  parameter int period_ns = 8
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  always #(period_ns / 2.0) clk = ~clk;   // Half period per toggle

endmodule

`default_nettype wire

// File: hdl/sched_top.sv
/* Scheduler top: bitinfo ROM, parser, table, dispatcher and AXI4-Lite registers.
   The table fills by itself after reset; lookups before that are ignored */
`default_nettype none

module sched_top #(
  parameter int MAX_ACCS = 16,
  parameter int MAX_ACC_TYPES = 16
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  sched_pkg::axil_req_t axil_req,
  output sched_pkg::axil_rsp_t axil_rsp
);

  localparam int addr_bits = $clog2(sched_pkg::bitinfo_depth(MAX_ACC_TYPES));
  localparam int tbl_bits  = $clog2(MAX_ACC_TYPES);

  logic [addr_bits-1:0]    bitinfo_addr;
  logic                    bitinfo_en;
  logic [31:0]             bitinfo_dout;
  logic                    tbl_a_en;
  logic [tbl_bits-1:0]     tbl_a_addr;
  sched_pkg::sched_entry_t tbl_a_din;
  logic [tbl_bits-1:0]     tbl_b_addr;
  sched_pkg::sched_entry_t tbl_b_dout;
  logic                    table_ready;
  logic [7:0]              num_types;
  logic                    lookup_start;
  logic [39:0]             lookup_type;
  logic                    lookup_done;
  logic                    found;
  logic [7:0]              acc_id;

  bitinfo_rom #(.MAX_ACC_TYPES(MAX_ACC_TYPES)) bitinfo_rom_inst (
    .clk, .bitinfo_en, .bitinfo_addr, .bitinfo_dout
  );

  sched_bitinfo_parser #(.MAX_ACCS(MAX_ACCS), .MAX_ACC_TYPES(MAX_ACC_TYPES))
    sched_bitinfo_parser_inst (
    .clk, .rstn, .bitinfo_addr, .bitinfo_en, .bitinfo_dout,
    .tbl_a_en, .tbl_a_addr, .tbl_a_din, .table_ready, .num_types
  );

  sched_table_ram #(.MAX_ACC_TYPES(MAX_ACC_TYPES)) sched_table_ram_inst (
    .clk, .tbl_a_en, .tbl_a_addr, .tbl_a_din, .tbl_b_addr, .tbl_b_dout
  );

  sched_dispatch #(.MAX_ACCS(MAX_ACCS), .MAX_ACC_TYPES(MAX_ACC_TYPES)) sched_dispatch_inst (
    .clk, .rstn, .lookup_start, .lookup_type, .num_types,
    .tbl_b_addr, .tbl_b_dout, .lookup_done, .found, .acc_id
  );

  sched_axil_regs sched_axil_regs_inst (
    .clk, .rstn, .axil_req, .axil_rsp, .lookup_start, .lookup_type,
    .lookup_done, .found, .acc_id, .table_ready, .num_types
  );

endmodule

`default_nettype wire

// File: hdl/sched_axil_regs.sv
/* AXI4-Lite slave for the lookup registers, one outstanding transfer per channel.
   Responses are always OKAY; a type_hi write while busy or before table ready is dropped */
`default_nettype none

module sched_axil_regs (
  input  logic                 clk,
  input  logic                 rstn,
  input  sched_pkg::axil_req_t axil_req,
  output sched_pkg::axil_rsp_t axil_rsp,
  output logic                 lookup_start,
  output logic [39:0]          lookup_type,
  input  logic                 lookup_done,
  input  logic                 found,
  input  logic [7:0]           acc_id,
  input  logic                 table_ready,
  input  logic [7:0]           num_types
);

  logic        aw_rdy;
  logic        bvalid;
  logic        ar_rdy;
  logic        rvalid;
  logic [31:0] rdata;
  logic [31:0] type_lo;
  logic [7:0]  type_hi;
  logic        busy;
  logic        res_found;
  logic [7:0]  res_id;
  logic        wr_fire;
  logic        rd_fire;
  logic        launch;
  logic [31:0] rd_word;

  assign wr_fire = aw_rdy && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = ar_rdy && axil_req.arvalid;
  assign launch  = wr_fire && axil_req.awaddr[3:0] == sched_pkg::reg_type_hi &&
                   table_ready && !busy;

  assign lookup_type = {type_hi, type_lo};

  assign axil_rsp = '{awready: aw_rdy, wready: aw_rdy, bvalid: bvalid, bresp: 2'b00,
                      arready: ar_rdy, rvalid: rvalid, rdata: rdata, rresp: 2'b00};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write channel and lookup control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_rdy       <= 1'b0;
      bvalid       <= 1'b0;
      lookup_start <= 1'b0;
      busy         <= 1'b0;
      res_found    <= 1'b0;
      res_id       <= '0;
    end else begin
      // Address and data are taken together, one cycle of ready
      aw_rdy <= !aw_rdy && !bvalid && axil_req.awvalid && axil_req.wvalid;
      if (bvalid && axil_req.bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
      end
      lookup_start <= launch;
      if (launch) begin
        busy <= 1'b1;
      end else if (lookup_done) begin
        busy      <= 1'b0;
        res_found <= found;
        res_id    <= acc_id;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      if (axil_req.awaddr[3:0] == sched_pkg::reg_type_lo) begin
        for (int b = 0; b < 4; b++) begin
          if (axil_req.wstrb[b]) begin
            type_lo[8*b +: 8] <= axil_req.wdata[8*b +: 8];
          end
        end
      end
      if (axil_req.awaddr[3:0] == sched_pkg::reg_type_hi && axil_req.wstrb[0]) begin
        type_hi <= axil_req.wdata[7:0];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_word = '0;   // Unknown and write-only offsets read as zero
    case (axil_req.araddr[3:0])
      sched_pkg::reg_result: begin
        rd_word[sched_pkg::res_busy_bit]  = busy;
        rd_word[sched_pkg::res_found_bit] = res_found;
        rd_word[sched_pkg::res_ready_bit] = table_ready;
        rd_word[7:0]                      = res_id;
      end
      sched_pkg::reg_num_types: rd_word = 32'(num_types);
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ar_rdy <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      ar_rdy <= !ar_rdy && !rvalid && axil_req.arvalid;
      if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;   // Held stable while rvalid waits on rready
    end
  end

endmodule

`default_nettype wire

// File: scheduler/sched_dispatch.sv
/* Linear table search, two cycles per entry, first match wins.
   Round-robin position is kept per table entry and does not track busy accelerators */
`default_nettype none

module sched_dispatch #(
  parameter int MAX_ACCS = 16,
  parameter int MAX_ACC_TYPES = 16,
  localparam int tbl_bits = $clog2(MAX_ACC_TYPES)
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    lookup_start,
  input  logic [39:0]             lookup_type,
  input  logic [7:0]              num_types,
  output logic [tbl_bits-1:0]     tbl_b_addr,
  input  sched_pkg::sched_entry_t tbl_b_dout,
  output logic                    lookup_done,
  output logic                    found,
  output logic [7:0]              acc_id
);

  localparam int acc_bits = $clog2(MAX_ACCS);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_cmp
  } state_t;

  state_t state;

  logic [tbl_bits-1:0] idx;
  logic [39:0]         want;
  logic [acc_bits-1:0] rr [MAX_ACC_TYPES];   // Next instance offset per entry
  logic                hit;
  logic                last;
  logic [acc_bits-1:0] pick;
  logic [acc_bits-1:0] rr_next;

  assign tbl_b_addr = idx;
  assign hit  = tbl_b_dout.task_type == want;
  assign last = 8'(idx) + 8'd1 == num_types;
  assign pick = acc_bits'(tbl_b_dout.acc_id[acc_bits-1:0] + rr[idx]);
  assign rr_next = (rr[idx] == tbl_b_dout.count_m1[acc_bits-1:0]) ? '0 : rr[idx] + 1'b1;

  always_ff @(posedge clk) begin
    if (state == st_idle && lookup_start) begin
      want <= lookup_type;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= st_idle;
      idx         <= '0;
      lookup_done <= 1'b0;
      found       <= 1'b0;
      acc_id      <= '0;
      for (int i = 0; i < MAX_ACC_TYPES; i++) begin
        rr[i] <= '0;
      end
    end else begin
      lookup_done <= 1'b0;
      case (state)
        st_idle: begin
          if (lookup_start) begin
            idx <= '0;
            if (num_types == 8'd0) begin     // Empty table answers at once
              lookup_done <= 1'b1;
              found       <= 1'b0;
              acc_id      <= '0;
            end else begin
              state <= st_issue;
            end
          end
        end
        st_issue: state <= st_cmp;   // Table read in flight
        st_cmp: begin
          if (hit) begin
            lookup_done <= 1'b1;
            found       <= 1'b1;
            acc_id      <= 8'(pick);
            rr[idx]     <= rr_next;
            state       <= st_idle;
          end else if (last) begin
            lookup_done <= 1'b1;
            found       <= 1'b0;
            acc_id      <= '0;
            state       <= st_idle;
          end else begin
            idx   <= idx + 1'b1;
            state <= st_issue;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: scheduler/sched_table_ram.sv
/* Scheduling table, one entry per accelerator type.
   Port B read data appears one cycle after the address */
`default_nettype none

module sched_table_ram #(
  parameter int MAX_ACC_TYPES = 16,
  localparam int tbl_bits = $clog2(MAX_ACC_TYPES)
) (
  input  logic                    clk,
  input  logic                    tbl_a_en,
  input  logic [tbl_bits-1:0]     tbl_a_addr,
  input  sched_pkg::sched_entry_t tbl_a_din,
  input  logic [tbl_bits-1:0]     tbl_b_addr,
  output sched_pkg::sched_entry_t tbl_b_dout
);

  sched_pkg::sched_entry_t mem [MAX_ACC_TYPES];

  always_ff @(posedge clk) begin
    if (tbl_a_en) begin
      mem[tbl_a_addr] <= tbl_a_din;
    end
  end

  always_ff @(posedge clk) begin
    tbl_b_dout <= mem[tbl_b_addr];
  end

endmodule

`default_nettype wire

// File: scheduler/sched_bitinfo_parser.sv
/* Walks the bitinfo once after reset and fills the scheduling table.
   Five cycles per type, four for the end marker; no reload afterwards */
`default_nettype none

module sched_bitinfo_parser #(
  parameter int MAX_ACCS = 16,
  parameter int MAX_ACC_TYPES = 16,
  localparam int addr_bits = $clog2(sched_pkg::bitinfo_depth(MAX_ACC_TYPES)),
  localparam int tbl_bits = $clog2(MAX_ACC_TYPES)
) (
  input  logic                   clk,
  input  logic                   rstn,
  output logic [addr_bits-1:0]   bitinfo_addr,
  output logic                   bitinfo_en,
  input  logic [31:0]            bitinfo_dout,
  output logic                   tbl_a_en,
  output logic [tbl_bits-1:0]    tbl_a_addr,
  output sched_pkg::sched_entry_t tbl_a_din,
  output logic                   table_ready,
  output logic [7:0]             num_types
);

  localparam int acc_bits = $clog2(MAX_ACCS);

  typedef enum logic [2:0] {
    st_start,
    st_issue,
    st_rd0,
    st_rd1,
    st_write,
    st_check,
    st_done
  } state_t;

  state_t state;

  logic [addr_bits-1:0] offset;
  logic [acc_bits-1:0]  first_id;
  logic [31:0]          word0;
  logic [23:0]          type_hi;
  logic [acc_bits:0]    count;      // One bit wider so MAX_ACCS instances fit
  logic [acc_bits-1:0]  count_m1;
  logic                 is_end;

  assign count    = word0[acc_bits:0];
  assign count_m1 = acc_bits'(count - 1'b1);
  assign is_end   = word0 == sched_pkg::bitinfo_end_word;

  assign bitinfo_addr = offset;
  assign bitinfo_en   = state == st_issue || state == st_rd0;
  assign tbl_a_en     = state == st_write;
  assign tbl_a_addr   = num_types[tbl_bits-1:0];
  assign table_ready  = state == st_done;

  assign tbl_a_din.task_type = {type_hi, word0[31:sched_pkg::w0_type_lsb]};
  assign tbl_a_din.acc_id    = 8'(first_id);
  assign tbl_a_din.count_m1  = 8'(count_m1);

  // Word captures, the ROM answers one cycle after en
  always_ff @(posedge clk) begin
    if (state == st_rd0) begin
      word0 <= bitinfo_dout;
    end
    if (state == st_rd1) begin
      type_hi <= bitinfo_dout[sched_pkg::w1_type_msb:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= st_start;
      offset    <= addr_bits'(sched_pkg::xtasks_config_offset);
      first_id  <= '0;
      num_types <= '0;
    end else begin
      case (state)
        st_start: state <= st_issue;
        st_issue: begin
          offset <= offset + 1'b1;  // Word1 follows word0
          state  <= st_rd0;
        end
        st_rd0: begin
          offset <= offset + addr_bits'(sched_pkg::words_per_acc_type - 1);
          state  <= st_rd1;
        end
        // Word0 is in hand here, so the end marker skips the write
        st_rd1: state <= is_end ? st_check : st_write;
        st_write: begin
          num_types <= num_types + 1'b1;
          first_id  <= acc_bits'(first_id + count);
          state     <= st_check;
        end
        st_check: begin
          if (is_end || num_types == 8'(MAX_ACC_TYPES)) begin
            state <= st_done;
          end else begin
            state <= st_issue;
          end
        end
        default: state <= st_done;   // Parsed, stays here until reset
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/bitinfo_rom.sv
/* Read-only bitinfo memory, contents taken from bitinfo.hex at start.
   Output register holds its value while en is low */
`default_nettype none

module bitinfo_rom #(
  parameter int MAX_ACC_TYPES = 16,
  localparam int depth = sched_pkg::bitinfo_depth(MAX_ACC_TYPES),
  localparam int addr_bits = $clog2(depth)
) (
  input  logic                 clk,
  input  logic                 bitinfo_en,
  input  logic [addr_bits-1:0] bitinfo_addr,   // Word index
  output logic [31:0]          bitinfo_dout
);

  logic [31:0] mem [depth];

  initial begin
    $readmemh("bitinfo.hex", mem);
  end

  always_ff @(posedge clk) begin
    if (bitinfo_en) begin
      bitinfo_dout <= mem[bitinfo_addr];
    end
  end

endmodule

`default_nettype wire

// File: common/sched_pkg.sv
/* Shared layout for the accelerator scheduler. Ids and counts travel as 8 bits,
   so MAX_ACCS and MAX_ACC_TYPES must both stay at or below 256 */
`default_nettype none

package sched_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bitinfo layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int task_type_bits       = 40;
  localparam int words_per_acc_type   = 11;
  localparam int xtasks_config_offset = 22;                // First type record
  localparam logic [31:0] bitinfo_end_word = 32'hFFFF_FFFF;

  localparam int w0_type_lsb = 16;     // Word0 [31:16] carries type [15:0]
  localparam int w1_type_msb = 23;     // Word1 [23:0] carries type [39:16]

  localparam int id_bits = 8;

  // Words needed to hold the header plus every type record
  function automatic int bitinfo_depth(input int max_types);
    return xtasks_config_offset + words_per_acc_type * max_types;
  endfunction

  typedef struct packed {
    logic [task_type_bits-1:0] task_type;
    logic [id_bits-1:0]        acc_id;     // First id of this type
    logic [id_bits-1:0]        count_m1;   // Instances minus one
  } sched_entry_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register map, byte offsets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [3:0] reg_type_lo   = 4'h0;
  localparam logic [3:0] reg_type_hi   = 4'h4;   // Write launches a lookup
  localparam logic [3:0] reg_result    = 4'h8;
  localparam logic [3:0] reg_num_types = 4'hC;

  localparam int res_busy_bit  = 31;
  localparam int res_found_bit = 30;
  localparam int res_ready_bit = 29;

  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire
